// File: src/uart_pkg.sv
package uart_pkg;

	// Register select produced by the address decoder
	typedef enum logic [1:0]
	{
		REG_NONE,
		REG_STATUS,
		REG_RX,
		REG_TX
	} uart_reg_t;

	// Byte offsets from the peripheral base address
	localparam logic [31:0] STATUS_OFFSET = 32'd0;
	localparam logic [31:0] RX_OFFSET = 32'd4;
	localparam logic [31:0] TX_OFFSET = 32'd8;

	// Status word bit positions
	localparam int STAT_TX_READY = 0;
	localparam int STAT_RX_AVAIL = 1;
	localparam int STAT_OVERRUN = 2;
	localparam int STAT_FRAME_ERR = 3;

	// Transmit engine states
	typedef enum logic [1:0]
	{
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	// Receive engine states
	typedef enum logic [1:0]
	{
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	typedef logic [7:0] char_t;

endpackage

// File: src/io_reg_if.sv
interface io_reg_if;

	// Registered launch of a transmit character
	logic tx_start;
	uart_pkg::char_t tx_char;

	// Combinational pop of the receive queue head
	logic rx_pop;

	// Which register the current address points at
	uart_pkg::uart_reg_t read_sel;

	modport decoder
	(
		output tx_start,
		output tx_char,
		output rx_pop,
		output read_sel
	);

	modport transmitter
	(
		input tx_start,
		input tx_char
	);

	modport queue
	(
		input rx_pop,
		input read_sel
	);

endinterface

// File: src/uart_reg_decode.sv
module uart_reg_decode
	#(parameter logic [31:0] BASE_ADDRESS = 32'h0)
	(
		input clk,
		input reset,
		input [31:0] io_address,
		input io_read_en,
		input io_write_en,
		input [31:0] io_write_data,
		io_reg_if.decoder regs
	);

	uart_pkg::uart_reg_t sel;

	// Address match against each register
	always_comb
	begin
		if (io_address == BASE_ADDRESS + uart_pkg::STATUS_OFFSET)
			sel = uart_pkg::REG_STATUS;
		else if (io_address == BASE_ADDRESS + uart_pkg::RX_OFFSET)
			sel = uart_pkg::REG_RX;
		else if (io_address == BASE_ADDRESS + uart_pkg::TX_OFFSET)
			sel = uart_pkg::REG_TX;
		else
			sel = uart_pkg::REG_NONE;
	end

	assign regs.read_sel = sel;

	// Pop takes effect at the next edge in the queue
	assign regs.rx_pop = io_read_en && sel == uart_pkg::REG_RX;

	// Launch pulse, one cycle after the bus write
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			regs.tx_start <= 1'b0;
		else
			regs.tx_start <= io_write_en && sel == uart_pkg::REG_TX;
	end

	// Character captured alongside the launch pulse
	always_ff @(posedge clk)
	begin
		if (io_write_en && sel == uart_pkg::REG_TX)
			regs.tx_char <= io_write_data[7:0];
	end

	// Bus master drives one strobe at a time
	assert property (@(posedge clk) disable iff (reset) !(io_read_en && io_write_en))
		else $error("read and write strobes both high");

endmodule

// File: src/uart_transmit.sv
module uart_transmit
	#(parameter int CLOCKS_PER_BIT = 16)
	(
		input clk,
		input reset,
		io_reg_if.transmitter regs,
		output logic tx_ready,
		output logic uart_tx
	);

	localparam int CNT_W = $clog2(CLOCKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] BIT_LOAD = CNT_W'(CLOCKS_PER_BIT - 1);

	uart_pkg::tx_state_t state;
	logic [CNT_W-1:0] clk_count;
	logic [2:0] bit_index;
	uart_pkg::char_t shift;

	// Frame sequencer, each state lasts one bit period
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= uart_pkg::TX_IDLE;
			clk_count <= '0;
			bit_index <= '0;
		end
		else
		begin
			case (state)
				uart_pkg::TX_IDLE:
				begin
					if (regs.tx_start)
					begin
						state <= uart_pkg::TX_START;
						clk_count <= BIT_LOAD;
					end
				end

				uart_pkg::TX_START:
				begin
					if (clk_count == '0)
					begin
						state <= uart_pkg::TX_DATA;
						clk_count <= BIT_LOAD;
						bit_index <= '0;
					end
					else
						clk_count <= clk_count - 1'b1;
				end

				uart_pkg::TX_DATA:
				begin
					if (clk_count == '0)
					begin
						clk_count <= BIT_LOAD;
						bit_index <= bit_index + 1'b1;
						// Last data bit hands over to stop
						if (bit_index == 3'd7)
							state <= uart_pkg::TX_STOP;
					end
					else
						clk_count <= clk_count - 1'b1;
				end

				default:
				begin
					if (clk_count == '0)
						state <= uart_pkg::TX_IDLE;
					else
						clk_count <= clk_count - 1'b1;
				end
			endcase
		end
	end

	// Shift out LSB first
	always_ff @(posedge clk)
	begin
		if (state == uart_pkg::TX_IDLE && regs.tx_start)
			shift <= regs.tx_char;
		else if (state == uart_pkg::TX_DATA && clk_count == '0)
			shift <= shift >> 1;
	end

	assign tx_ready = state == uart_pkg::TX_IDLE;

	// Line level per frame section, idle high
	always_comb
	begin
		case (state)
			uart_pkg::TX_START: uart_tx = 1'b0;
			uart_pkg::TX_DATA: uart_tx = shift[0];
			default: uart_tx = 1'b1;
		endcase
	end

	// A write that lands mid-frame is lost
	assert property (@(posedge clk) disable iff (reset)
		regs.tx_start |-> state == uart_pkg::TX_IDLE)
		else $warning("transmit write dropped, transmitter busy");

endmodule

// File: src/uart_receive.sv
module uart_receive
	#(parameter int CLOCKS_PER_BIT = 16)
	(
		input clk,
		input reset,
		input uart_rx,
		output logic rx_char_valid,
		output uart_pkg::char_t rx_char,
		output logic rx_frame_error
	);

	localparam int CNT_W = $clog2(CLOCKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] BIT_LOAD = CNT_W'(CLOCKS_PER_BIT - 1);
	// Lands the start check near the middle of the start bit
	localparam logic [CNT_W-1:0] HALF_LOAD =
		CNT_W'((CLOCKS_PER_BIT >= 2) ? CLOCKS_PER_BIT / 2 - 1 : 0);

	uart_pkg::rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic falling;
	logic [CNT_W-1:0] clk_count;
	logic [2:0] bit_index;

	// Two-flop synchronizer plus one more stage for edge detect
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign falling = rx_prev && !rx_sync;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= uart_pkg::RX_IDLE;
			clk_count <= '0;
			bit_index <= '0;
			rx_char_valid <= 1'b0;
			rx_frame_error <= 1'b0;
		end
		else
		begin
			rx_char_valid <= 1'b0;
			case (state)
				uart_pkg::RX_IDLE:
				begin
					if (falling)
					begin
						state <= uart_pkg::RX_START;
						clk_count <= HALF_LOAD;
					end
				end

				uart_pkg::RX_START:
				begin
					if (clk_count != '0)
						clk_count <= clk_count - 1'b1;
					else if (rx_sync)
						// Glitch, not a real start bit
						state <= uart_pkg::RX_IDLE;
					else
					begin
						state <= uart_pkg::RX_DATA;
						clk_count <= BIT_LOAD;
						bit_index <= '0;
					end
				end

				uart_pkg::RX_DATA:
				begin
					if (clk_count == '0)
					begin
						clk_count <= BIT_LOAD;
						bit_index <= bit_index + 1'b1;
						if (bit_index == 3'd7)
							state <= uart_pkg::RX_STOP;
					end
					else
						clk_count <= clk_count - 1'b1;
				end

				default:
				begin
					if (clk_count == '0)
					begin
						// Stop bit must read high
						rx_frame_error <= !rx_sync;
						rx_char_valid <= 1'b1;
						state <= uart_pkg::RX_IDLE;
					end
					else
						clk_count <= clk_count - 1'b1;
				end
			endcase
		end
	end

	// Data bits enter at the top, LSB ends up at bit 0
	always_ff @(posedge clk)
	begin
		if (state == uart_pkg::RX_DATA && clk_count == '0)
			rx_char <= {rx_sync, rx_char[7:1]};
	end

	// Queue pushes once per frame
	assert property (@(posedge clk) disable iff (reset) rx_char_valid |=> !rx_char_valid)
		else $error("rx_char_valid held longer than one cycle");

endmodule

// File: src/uart_rx_queue.sv
module uart_rx_queue
	#(parameter int FIFO_LENGTH = 8)
	(
		input clk,
		input reset,
		io_reg_if.queue regs,
		input rx_char_valid,
		input uart_pkg::char_t rx_char,
		input rx_frame_error,
		input tx_ready,
		output logic [31:0] io_read_data
	);

	localparam int PTR_W = (FIFO_LENGTH > 1) ? $clog2(FIFO_LENGTH) : 1;
	localparam int CNT_W = $clog2(FIFO_LENGTH + 1);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_LENGTH - 1);
	localparam logic [CNT_W-1:0] ALMOST_FULL = CNT_W'(FIFO_LENGTH - 1);

	// Each entry is frame error above the character
	logic [8:0] fifo_data [FIFO_LENGTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic overrun;
	logic empty;
	logic pop;
	logic overrun_drop;
	logic dequeue;
	logic [8:0] head;
	logic [31:0] status_word;

	assign empty = count == '0;
	assign pop = regs.rx_pop && !empty;
	// Make room by discarding the oldest character
	assign overrun_drop = rx_char_valid && count == ALMOST_FULL;
	assign dequeue = pop || overrun_drop;

	always_ff @(posedge clk)
	begin
		if (rx_char_valid)
			fifo_data[wr_ptr] <= {rx_frame_error, rx_char};
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (rx_char_valid)
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			if (dequeue)
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			// Push and dequeue together leave the count alone
			if (rx_char_valid && !dequeue)
				count <= count + 1'b1;
			else if (dequeue && !rx_char_valid)
				count <= count - 1'b1;
		end
	end

	// Sticky overrun, set beats clear
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			overrun <= 1'b0;
		else if (overrun_drop)
			overrun <= 1'b1;
		else if (regs.rx_pop)
			overrun <= 1'b0;
	end

	// Empty queue reads back as zero
	assign head = empty ? 9'd0 : fifo_data[rd_ptr];

	always_comb
	begin
		status_word = '0;
		status_word[uart_pkg::STAT_TX_READY] = tx_ready;
		status_word[uart_pkg::STAT_RX_AVAIL] = !empty;
		status_word[uart_pkg::STAT_OVERRUN] = overrun;
		status_word[uart_pkg::STAT_FRAME_ERR] = head[8];
	end

	// Anything other than status returns the head character
	always_comb
	begin
		if (regs.read_sel == uart_pkg::REG_STATUS)
			io_read_data = status_word;
		else
			io_read_data = {24'd0, head[7:0]};
	end

	assert property (@(posedge clk) disable iff (reset) count <= CNT_W'(FIFO_LENGTH))
		else $error("receive queue count above FIFO_LENGTH");

endmodule

// File: src/uart.sv
module uart
	#(
		parameter logic [31:0] BASE_ADDRESS = 32'h0,
		parameter int CLOCKS_PER_BIT = 16,
		parameter int FIFO_LENGTH = 8
	)
	(
		input clk,
		input reset,
		input [31:0] io_address,
		input io_read_en,
		input [31:0] io_write_data,
		input io_write_en,
		output logic [31:0] io_read_data,
		output logic uart_tx,
		input uart_rx
	);

	// Receive engine to queue
	logic rx_char_valid;
	uart_pkg::char_t rx_char;
	logic rx_frame_error;
	// Transmit idle, reported in status
	logic tx_ready;

	io_reg_if regs();

	uart_reg_decode #(.BASE_ADDRESS(BASE_ADDRESS)) u_decode
	(
		.clk(clk),
		.reset(reset),
		.io_address(io_address),
		.io_read_en(io_read_en),
		.io_write_en(io_write_en),
		.io_write_data(io_write_data),
		.regs(regs)
	);

	uart_transmit #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) u_transmit
	(
		.clk(clk),
		.reset(reset),
		.regs(regs),
		.tx_ready(tx_ready),
		.uart_tx(uart_tx)
	);

	uart_receive #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) u_receive
	(
		.clk(clk),
		.reset(reset),
		.uart_rx(uart_rx),
		.rx_char_valid(rx_char_valid),
		.rx_char(rx_char),
		.rx_frame_error(rx_frame_error)
	);

	uart_rx_queue #(.FIFO_LENGTH(FIFO_LENGTH)) u_rx_queue
	(
		.clk(clk),
		.reset(reset),
		.regs(regs),
		.rx_char_valid(rx_char_valid),
		.rx_char(rx_char),
		.rx_frame_error(rx_frame_error),
		.tx_ready(tx_ready),
		.io_read_data(io_read_data)
	);

endmodule

// File: verif/uart_tb.sv
module uart_tb;

	localparam logic [31:0] BASE_ADDRESS = 32'h100;
	localparam int CLOCKS_PER_BIT = 4;
	localparam int FIFO_LENGTH = 8;
	// 10 transmit, 10 receive, 2 frame error, 10 overrun
	localparam int TOTAL_FRAMES = 32;
	localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * 10 * CLOCKS_PER_BIT * 2;

	logic clk;
	logic reset;
	logic [31:0] io_address;
	logic io_read_en;
	logic [31:0] io_write_data;
	logic io_write_en;
	logic [31:0] io_read_data;
	logic uart_tx;
	logic uart_rx;

	// Posedges seen since time zero
	int cycle = 0;
	// Cycle at which a read or write was sampled
	int sample_cycle = 0;
	int write_cycle = 0;
	// First cycle the transmitter is idle again
	int tx_free_cycle = 0;
	int errors = 0;
	int frames_sent = 0;
	int rx_pushes = 0;

	// Reference model state
	logic [8:0] model_rx[$];
	logic model_overrun = 1'b0;
	uart_pkg::char_t tx_sent[$];
	uart_pkg::char_t tx_seen[$];

	uart #(
		.BASE_ADDRESS(BASE_ADDRESS),
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT),
		.FIFO_LENGTH(FIFO_LENGTH)
	) u_uart
	(
		.clk(clk),
		.reset(reset),
		.io_address(io_address),
		.io_read_en(io_read_en),
		.io_write_data(io_write_data),
		.io_write_en(io_write_en),
		.io_read_data(io_read_data),
		.uart_tx(uart_tx),
		.uart_rx(uart_rx)
	);

	initial
		clk = 1'b0;

	always #4 clk = ~clk;

	// Cycle count and run limit
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
			fail_run();
		end
	end

	// Receive engine output pulses count as the done marker
	always @(posedge clk)
	begin
		if (u_uart.rx_char_valid)
			rx_pushes <= rx_pushes + 1;
	end

	task automatic fail_run();
		errors++;
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping on first error");
	endtask

	task automatic check_word(input string name, input uart_pkg::char_t expected,
		input uart_pkg::char_t actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s expected %02h actual %02h", $time, name, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_status(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s expected %08h actual %08h", $time, name, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_level(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
			fail_run();
		end
	endtask

	// Status word from the model's view of the peripheral
	function automatic logic [31:0] expected_status(input logic tx_ready, input int depth,
		input logic overrun, input logic head_err);
		logic [31:0] word;
		word = '0;
		word[uart_pkg::STAT_TX_READY] = tx_ready;
		word[uart_pkg::STAT_RX_AVAIL] = depth != 0;
		word[uart_pkg::STAT_OVERRUN] = overrun;
		word[uart_pkg::STAT_FRAME_ERR] = head_err;
		return word;
	endfunction

	// Combinational read sampled mid-cycle
	task automatic bus_read(input logic [31:0] address, output logic [31:0] data);
		@(posedge clk);
		io_address <= address;
		io_read_en <= 1'b1;
		@(negedge clk);
		data = io_read_data;
		sample_cycle = cycle;
		@(posedge clk);
		io_read_en <= 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] address, input logic [31:0] data);
		@(posedge clk);
		io_address <= address;
		io_write_data <= data;
		io_write_en <= 1'b1;
		@(posedge clk);
		io_write_en <= 1'b0;
		// Edge that took the strobe
		@(negedge clk);
		write_cycle = cycle;
	endtask

	task automatic verify_status(output logic [31:0] word);
		logic head_err;
		logic tx_ready;
		bus_read(BASE_ADDRESS + uart_pkg::STATUS_OFFSET, word);
		head_err = (model_rx.size() != 0) ? model_rx[0][8] : 1'b0;
		tx_ready = sample_cycle >= tx_free_cycle;
		check_status("io_read_data (status)",
			expected_status(tx_ready, model_rx.size(), model_overrun, head_err), word);
	endtask

	// Pop the head and compare against the model
	task automatic read_rx_and_check();
		logic [31:0] word;
		logic [8:0] expected;
		expected = model_rx.pop_front();
		bus_read(BASE_ADDRESS + uart_pkg::RX_OFFSET, word);
		model_overrun = 1'b0;
		check_word("io_read_data (rx)", expected[7:0], word[7:0]);
		// Upper bits of a character read stay zero
		check_status("io_read_data (rx upper)", 32'd0, {word[31:8], 8'd0});
	endtask

	task automatic transmit_char(input uart_pkg::char_t data);
		logic [31:0] word;
		// Poll until the transmitter is idle
		verify_status(word);
		while (!word[uart_pkg::STAT_TX_READY])
			verify_status(word);
		tx_sent.push_back(data);
		bus_write(BASE_ADDRESS + uart_pkg::TX_OFFSET, {24'd0, data});
		// Launch edge plus ten bit periods
		tx_free_cycle = write_cycle + 1 + 10 * CLOCKS_PER_BIT;
	endtask

	task automatic drive_bit(input logic level);
		@(posedge clk);
		uart_rx <= level;
		repeat (CLOCKS_PER_BIT - 1)
			@(posedge clk);
	endtask

	// One 8N1 frame on uart_rx with selectable stop level
	task automatic receive_char(input uart_pkg::char_t data, input logic stop_level);
		frames_sent++;
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(data[i]);
		drive_bit(stop_level);
		// Idle high so the next start has a falling edge
		drive_bit(1'b1);
		wait (rx_pushes == frames_sent);
		// Oldest entry goes when almost full
		if (model_rx.size() == FIFO_LENGTH - 1)
		begin
			model_rx.delete(0);
			model_overrun = 1'b1;
		end
		model_rx.push_back({~stop_level, data});
	endtask

	// Decode transmit frames by sampling near mid-bit
	initial
	begin
		uart_pkg::char_t data;
		forever
		begin
			@(negedge uart_tx);
			repeat (CLOCKS_PER_BIT / 2)
				@(negedge clk);
			if (uart_tx !== 1'b0)
			begin
				$display("Transmit start bit was not low at mid-bit, time %0t", $time);
				fail_run();
			end
			for (int i = 0; i < 8; i++)
			begin
				repeat (CLOCKS_PER_BIT)
					@(negedge clk);
				data[i] = uart_tx;
			end
			repeat (CLOCKS_PER_BIT)
				@(negedge clk);
			if (uart_tx !== 1'b1)
			begin
				$display("Transmit stop bit was not high at mid-bit, time %0t", $time);
				fail_run();
			end
			tx_seen.push_back(data);
		end
	end

	initial
	begin
		logic [31:0] word;
		void'($urandom(78099));
		reset <= 1'b1;
		io_address <= '0;
		io_read_en <= 1'b0;
		io_write_data <= '0;
		io_write_en <= 1'b0;
		uart_rx <= 1'b1;
		repeat (2)
			@(posedge clk);
		reset <= 1'b0;

		// Idle line and only tx_ready set after reset
		verify_status(word);
		@(negedge clk);
		check_level("uart_tx", 1'b1, uart_tx);

		// Transmit path
		for (int i = 0; i < 10; i++)
			transmit_char(uart_pkg::char_t'($urandom()));
		wait (tx_seen.size() == tx_sent.size());
		for (int i = 0; i < tx_sent.size(); i++)
			check_word("uart_tx byte", tx_sent[i], tx_seen[i]);
		verify_status(word);

		// Receive path one character at a time
		for (int i = 0; i < 10; i++)
		begin
			receive_char(uart_pkg::char_t'($urandom()), 1'b1);
			verify_status(word);
			read_rx_and_check();
			verify_status(word);
		end

		// Low stop bit flags the head entry
		receive_char(uart_pkg::char_t'($urandom()), 1'b0);
		verify_status(word);
		read_rx_and_check();
		receive_char(uart_pkg::char_t'($urandom()), 1'b1);
		verify_status(word);
		read_rx_and_check();
		verify_status(word);

		// Ten frames into a queue that holds seven
		for (int i = 0; i < 10; i++)
		begin
			receive_char(uart_pkg::char_t'($urandom()), 1'b1);
			verify_status(word);
		end
		while (model_rx.size() != 0)
		begin
			read_rx_and_check();
			verify_status(word);
		end

		if (errors == 0)
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
		else
			fail_run();
	end

endmodule

// File: verilog.f
src/uart_pkg.sv
src/io_reg_if.sv
src/uart_reg_decode.sv
src/uart_transmit.sv
src/uart_receive.sv
src/uart_rx_queue.sv
src/uart.sv
verif/uart_tb.sv

// File: Bender.yml
package:
  name: uart

sources:
  - src/uart_pkg.sv
  - src/io_reg_if.sv
  - src/uart_reg_decode.sv
  - src/uart_transmit.sv
  - src/uart_receive.sv
  - src/uart_rx_queue.sv
  - src/uart.sv
  - target: test
    files:
      - verif/uart_tb.sv
